/* design/biq_pkg.sv */
package biq_pkg;

   ////////////////////
   // Word geometry
   ////////////////////

   // Ten decimal digits per operand word
   localparam int num_digits = 10;

   // One digit is a 2-of-7 bi-quinary code
   localparam int digit_bits = 7;

   // Digit i sits at bits [i*digit_bits +: digit_bits], digit 0 is least significant
   localparam int word_bits = num_digits * digit_bits;

   ////////////////////
   // Digit code layout
   ////////////////////

   // The two bi bits sit on top, the five quinary bits below them
   // A valid digit has exactly one bi bit and exactly one quinary bit set
   localparam int biq_b5 = 6;
   localparam int biq_b0 = 5;
   localparam int biq_q4 = 4;
   localparam int biq_q3 = 3;
   localparam int biq_q2 = 2;
   localparam int biq_q1 = 1;
   localparam int biq_q0 = 0;

   ////////////////////
   // Flow control
   ////////////////////

   // Result queue depth, also the input credits the sender starts with
   localparam int queue_depth = 4;

   // Credits the collector holds toward the receiver after reset
   localparam int out_credits_init = 2;

   // Width of the credit and occupancy counters, wide enough for queue_depth
   localparam int credit_bits = 3;

   ////////////////////
   // Opcode and result
   ////////////////////

   // Add, or subtract by nines complement of b with a carry-in of one
   typedef enum logic {
      op_add = 1'b0,
      op_sub = 1'b1
   } op_e;

   // One checked result word as it leaves the collector
   typedef struct packed {
      logic [word_bits-1:0] sum;
      // Carry out of digit nine, for subtract this is the a >= b test
      logic                 carry;
      // Every digit of the sum is zero
      logic                 zero;
      // Some digit failed the 2-of-7 check
      logic                 digit_err;
      // Some carry pair was not one-hot
      logic                 carry_err;
   } result_s;

endpackage

/* design/digit_bus_if.sv */
`timescale 1ns/1ps

// One operand digit pair on its way from the feeder to a single lane
interface digit_bus_if;

   // High for one cycle per word
   logic valid;

   // Operation applied to the whole word
   biq_pkg::op_e op;

   // Digit of operand a, 2-of-7 code
   logic [biq_pkg::digit_bits-1:0] a_digit;

   // Digit of operand b, still uncomplemented
   logic [biq_pkg::digit_bits-1:0] b_digit;

   // The feeder side drives everything
   modport src (
      output valid,
      output op,
      output a_digit,
      output b_digit
   );

   // The lane side only reads
   modport dst (
      input valid,
      input op,
      input a_digit,
      input b_digit
   );

endinterface

/* design/operand_feeder.sv */
`timescale 1ns/1ps

module operand_feeder (
   input  logic                          ap,
   input  logic                          rst,
   input  logic                          in_valid,
   input  biq_pkg::op_e                  in_op,
   input  logic [biq_pkg::word_bits-1:0] in_a,
   input  logic [biq_pkg::word_bits-1:0] in_b,
   digit_bus_if.src                      lanes [biq_pkg::num_digits],
   output logic                          carry_in0
);

   // Word register, one slot deep
   logic                          valid_q;
   biq_pkg::op_e                  op_q;
   logic [biq_pkg::word_bits-1:0] a_q;
   logic [biq_pkg::word_bits-1:0] b_q;

   // The sender only raises in_valid while it holds a credit
   // so a new word can be taken on every edge without a stall
   always_ff @(posedge ap) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   // Operands and op carry no reset, valid_q qualifies them
   always_ff @(posedge ap) begin
      if (in_valid) begin
         op_q <= in_op;
         a_q  <= in_a;
         b_q  <= in_b;
      end
   end

   ////////////////////
   // Lane fan-out
   ////////////////////

   // Each lane gets its own digit slice and a copy of valid and op
   for (genvar i = 0; i < biq_pkg::num_digits; i++) begin : g_lane
      assign lanes[i].valid   = valid_q;
      assign lanes[i].op      = op_q;
      assign lanes[i].a_digit = a_q[i*biq_pkg::digit_bits +: biq_pkg::digit_bits];
      assign lanes[i].b_digit = b_q[i*biq_pkg::digit_bits +: biq_pkg::digit_bits];
   end

   // Subtract is a + nines(b) + 1, so lane 0 starts with a carry
   assign carry_in0 = (op_q == biq_pkg::op_sub);

endmodule

/* design/biq_digit_lane.sv */
`timescale 1ns/1ps

module biq_digit_lane (
   input  logic                           ap,
   input  logic                           rst,
   digit_bus_if.dst                       bus,
   input  logic                           carry_in,
   output logic                           carry_out,
   output logic                           lane_valid,
   output logic [biq_pkg::digit_bits-1:0] sum_digit,
   output logic                           carry,
   output logic                           no_carry,
   output logic                           zero,
   output logic                           no_zero
);

   // Returns {code ok, binary value 0 to 9}
   function automatic logic [4:0] decode_digit(input logic [biq_pkg::digit_bits-1:0] code);
      logic [3:0] qv;
      logic       q_ok;
      logic       bi_ok;
      bi_ok = code[biq_pkg::biq_b0] ^ code[biq_pkg::biq_b5];
      q_ok  = 1'b1;
      qv    = 4'd0;
      // The quinary group must be one-hot
      case ({code[biq_pkg::biq_q4], code[biq_pkg::biq_q3], code[biq_pkg::biq_q2],
             code[biq_pkg::biq_q1], code[biq_pkg::biq_q0]})
         5'b00001: qv = 4'd0;
         5'b00010: qv = 4'd1;
         5'b00100: qv = 4'd2;
         5'b01000: qv = 4'd3;
         5'b10000: qv = 4'd4;
         default:  q_ok = 1'b0;
      endcase
      if (code[biq_pkg::biq_b5]) begin
         qv = qv + 4'd5;
      end
      return {bi_ok & q_ok, qv};
   endfunction

   // Value 0 to 9 back into 2-of-7 form
   function automatic logic [biq_pkg::digit_bits-1:0] encode_digit(input logic [3:0] val);
      logic [biq_pkg::digit_bits-1:0] code;
      logic [3:0]                     qv;
      code = '0;
      if (val >= 4'd5) begin
         code[biq_pkg::biq_b5] = 1'b1;
         qv = val - 4'd5;
      end else begin
         code[biq_pkg::biq_b0] = 1'b1;
         qv = val;
      end
      case (qv)
         4'd0:    code[biq_pkg::biq_q0] = 1'b1;
         4'd1:    code[biq_pkg::biq_q1] = 1'b1;
         4'd2:    code[biq_pkg::biq_q2] = 1'b1;
         4'd3:    code[biq_pkg::biq_q3] = 1'b1;
         default: code[biq_pkg::biq_q4] = 1'b1;
      endcase
      return code;
   endfunction

   logic [4:0]                     a_dec;
   logic [4:0]                     b_dec;
   logic [3:0]                     b_eff;
   logic [4:0]                     total;
   logic [4:0]                     total_adj;
   logic                           digits_ok;
   logic                           carry_gen;
   logic [biq_pkg::digit_bits-1:0] sum_code;

   always_comb begin
      a_dec = decode_digit(bus.a_digit);
      b_dec = decode_digit(bus.b_digit);
      // Nines complement of b for subtract
      b_eff = (bus.op == biq_pkg::op_sub) ? 4'd9 - b_dec[3:0] : b_dec[3:0];
      digits_ok = a_dec[4] & b_dec[4];
      total     = {1'b0, a_dec[3:0]} + {1'b0, b_eff} + {4'd0, carry_in};
      total_adj = total - 5'd10;
      carry_gen = (total >= 5'd10);
      // A bad input digit gives an all-zero code, which the collector flags
      if (digits_ok) begin
         sum_code = encode_digit(carry_gen ? total_adj[3:0] : total[3:0]);
      end else begin
         sum_code = '0;
      end
   end

   // Carry ripples on combinationally, forced low behind a bad digit
   assign carry_out = digits_ok & carry_gen;

   always_ff @(posedge ap) begin
      if (rst) begin
         lane_valid <= 1'b0;
      end else begin
         lane_valid <= bus.valid;
      end
   end

   // Dual-rail carry, both rails low when the digit was not checkable
   always_ff @(posedge ap) begin
      if (bus.valid) begin
         sum_digit <= sum_code;
         carry     <= digits_ok & carry_gen;
         no_carry  <= digits_ok & ~carry_gen;
         zero      <= sum_code[biq_pkg::biq_b0] & sum_code[biq_pkg::biq_q0];
         no_zero   <= sum_code[biq_pkg::biq_b5] | sum_code[biq_pkg::biq_q4]
                    | sum_code[biq_pkg::biq_q3] | sum_code[biq_pkg::biq_q2]
                    | sum_code[biq_pkg::biq_q1];
      end
   end

endmodule

/* design/check_collector.sv */
`timescale 1ns/1ps

module check_collector (
   input  logic                           ap,
   input  logic                           rst,
   input  logic [biq_pkg::num_digits-1:0] lane_valid,
   input  logic [biq_pkg::word_bits-1:0]  sum_word,
   input  logic [biq_pkg::num_digits-1:0] carry,
   input  logic [biq_pkg::num_digits-1:0] no_carry,
   input  logic [biq_pkg::num_digits-1:0] zero,
   input  logic [biq_pkg::num_digits-1:0] no_zero,
   input  logic                           err_reset,
   input  logic                           out_credit,
   output logic                           out_valid,
   output biq_pkg::result_s               out_result,
   output logic                           in_credit,
   output logic                           check_latch
);

   localparam int ptr_bits = $clog2(biq_pkg::queue_depth);

   logic [biq_pkg::num_digits-1:0]  digit_err_vec;
   logic [biq_pkg::num_digits-1:0]  carry_err_vec;
   biq_pkg::result_s                new_result;
   logic                            push;
   logic                            pop;

   biq_pkg::result_s                queue_mem [biq_pkg::queue_depth];
   logic [ptr_bits-1:0]             wr_ptr;
   logic [ptr_bits-1:0]             rd_ptr;
   logic [biq_pkg::credit_bits-1:0] q_count;
   logic [biq_pkg::credit_bits-1:0] out_cnt;

   ////////////////////
   // Digit and carry checks
   ////////////////////

   // Zero and non-zero flags must disagree on every live digit
   assign digit_err_vec = lane_valid & ~(zero ^ no_zero);

   // Both rails high is always wrong, both low only matters on a live lane
   assign carry_err_vec = (carry & no_carry) | (lane_valid & ~carry & ~no_carry);

   always_comb begin
      new_result.sum       = sum_word;
      new_result.carry     = carry[biq_pkg::num_digits-1];
      new_result.zero      = &zero;
      new_result.digit_err = |digit_err_vec;
      new_result.carry_err = |carry_err_vec;
   end

   // All lanes are loaded together
   assign push = |lane_valid;

   ////////////////////
   // Result queue
   ////////////////////

   // A result leaves only while the receiver has granted room for it
   assign pop = (q_count != '0) && (out_cnt != '0);

   // At most queue_depth words are in flight, so a push never finds it full
   always_ff @(posedge ap) begin
      if (push) begin
         queue_mem[wr_ptr] <= new_result;
      end
   end

   always_ff @(posedge ap) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         q_count <= q_count + {{(biq_pkg::credit_bits-1){1'b0}}, push}
                            - {{(biq_pkg::credit_bits-1){1'b0}}, pop};
      end
   end

   // Output credits, spent on each pop and refilled by the receiver's pulses
   always_ff @(posedge ap) begin
      if (rst) begin
         out_cnt <= biq_pkg::credit_bits'(biq_pkg::out_credits_init);
      end else begin
         out_cnt <= out_cnt + {{(biq_pkg::credit_bits-1){1'b0}}, out_credit}
                            - {{(biq_pkg::credit_bits-1){1'b0}}, pop};
      end
   end

   ////////////////////
   // Output stage
   ////////////////////

   // Each popped result is presented for exactly one cycle
   always_ff @(posedge ap) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= pop;
      end
   end

   always_ff @(posedge ap) begin
      if (pop) begin
         out_result <= queue_mem[rd_ptr];
      end
   end

   // The departing word frees its slot upstream in the same cycle
   assign in_credit = out_valid;

   // Error reset wins over a fresh error in the same cycle
   always_ff @(posedge ap) begin
      if (rst) begin
         check_latch <= 1'b0;
      end else if (err_reset) begin
         check_latch <= 1'b0;
      end else if (out_valid && (out_result.digit_err || out_result.carry_err)) begin
         check_latch <= 1'b1;
      end
   end

endmodule

/* design/biq_check_adder.sv */
`timescale 1ns/1ps

module biq_check_adder (
   input  logic                          ap,
   input  logic                          rst,
   input  logic                          in_valid,
   input  biq_pkg::op_e                  in_op,
   input  logic [biq_pkg::word_bits-1:0] in_a,
   input  logic [biq_pkg::word_bits-1:0] in_b,
   output logic                          in_credit,
   output logic                          out_valid,
   output logic [biq_pkg::word_bits-1:0] out_sum,
   output logic                          out_carry,
   output logic                          out_zero,
   output logic                          out_digit_err,
   output logic                          out_carry_err,
   input  logic                          out_credit,
   input  logic                          err_reset,
   output logic                          check_latch
);

   digit_bus_if lane_bus [biq_pkg::num_digits] ();

   // carry_chain[i] is the carry into lane i
   logic [biq_pkg::num_digits-1:0] carry_chain;
   logic [biq_pkg::num_digits-1:0] lane_valid;
   logic [biq_pkg::word_bits-1:0]  sum_word;
   logic [biq_pkg::num_digits-1:0] carry;
   logic [biq_pkg::num_digits-1:0] no_carry;
   logic [biq_pkg::num_digits-1:0] zero;
   logic [biq_pkg::num_digits-1:0] no_zero;
   biq_pkg::result_s               out_result;

   operand_feeder operand_feeder_i (
      .ap        (ap),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_op     (in_op),
      .in_a      (in_a),
      .in_b      (in_b),
      .lanes     (lane_bus),
      .carry_in0 (carry_chain[0])
   );

   ////////////////////
   // Digit lanes
   ////////////////////

   for (genvar i = 0; i < biq_pkg::num_digits; i++) begin : g_lane
      if (i < biq_pkg::num_digits - 1) begin : g_mid
         biq_digit_lane biq_digit_lane_i (
            .ap         (ap),
            .rst        (rst),
            .bus        (lane_bus[i]),
            .carry_in   (carry_chain[i]),
            .carry_out  (carry_chain[i+1]),
            .lane_valid (lane_valid[i]),
            .sum_digit  (sum_word[i*biq_pkg::digit_bits +: biq_pkg::digit_bits]),
            .carry      (carry[i]),
            .no_carry   (no_carry[i]),
            .zero       (zero[i]),
            .no_zero    (no_zero[i])
         );
      end else begin : g_top
         // The word carry comes from the registered rail, so this carry_out stays open
         biq_digit_lane biq_digit_lane_i (
            .ap         (ap),
            .rst        (rst),
            .bus        (lane_bus[i]),
            .carry_in   (carry_chain[i]),
            .carry_out  (),
            .lane_valid (lane_valid[i]),
            .sum_digit  (sum_word[i*biq_pkg::digit_bits +: biq_pkg::digit_bits]),
            .carry      (carry[i]),
            .no_carry   (no_carry[i]),
            .zero       (zero[i]),
            .no_zero    (no_zero[i])
         );
      end
   end

   check_collector check_collector_i (
      .ap          (ap),
      .rst         (rst),
      .lane_valid  (lane_valid),
      .sum_word    (sum_word),
      .carry       (carry),
      .no_carry    (no_carry),
      .zero        (zero),
      .no_zero     (no_zero),
      .err_reset   (err_reset),
      .out_credit  (out_credit),
      .out_valid   (out_valid),
      .out_result  (out_result),
      .in_credit   (in_credit),
      .check_latch (check_latch)
   );

   // Result struct onto the plain output ports
   assign out_sum       = out_result.sum;
   assign out_carry     = out_result.carry;
   assign out_zero      = out_result.zero;
   assign out_digit_err = out_result.digit_err;
   assign out_carry_err = out_result.carry_err;

endmodule

/* tests/biq_check_adder_checker.sv */
`timescale 1ns/1ps

module biq_check_adder_checker (
   input logic ap,
   input logic rst,
   input logic in_credit,
   input logic out_valid,
   input logic out_credit,
   input logic err_reset,
   input logic check_latch
);

   // Shadow of the output credits as the receiver sees them
   // A departure is only visible one cycle after the collector spent its credit
   int avail_credits;

   always_ff @(posedge ap) begin
      if (rst) begin
         avail_credits <= biq_pkg::out_credits_init;
      end else begin
         avail_credits <= avail_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
      end
   end

   ////////////////////
   // Credit protocol
   ////////////////////

   // A credit goes back upstream only with a departing result
   a_credit_with_valid : assert property (@(posedge ap) disable iff (rst)
      in_credit |-> out_valid)
      else $error("in_credit pulsed without out_valid");

   // The collector held at least one unspent credit in the cycle before a result left
   a_valid_needs_credit : assert property (@(posedge ap) disable iff (rst)
      out_valid |-> ($past(avail_credits) - ($past(out_valid) ? 1 : 0)) > 0)
      else $error("out_valid raised with no output credit held");

   ////////////////////
   // Check latch
   ////////////////////

   // err_reset clears the latch even against a new error
   a_latch_cleared : assert property (@(posedge ap) disable iff (rst)
      err_reset |=> !check_latch)
      else $error("check_latch still set after err_reset");

   // Reset leaves every output strobe and the latch low
   a_reset_quiet : assert property (@(posedge ap)
      rst |=> (!out_valid && !in_credit && !check_latch))
      else $error("outputs not quiet after reset");

endmodule

/* tests/biq_check_adder_tb.sv */
`timescale 1ns/1ps

module biq_check_adder_tb;

   localparam int period         = 40;
   localparam int reset_cycles   = 3;
   localparam int num_words      = 300;
   // Output credits are held back this long after reset so the queue fills
   localparam int hold_cycles    = 24;
   // Worst-case cycles between two words under random credit returns
   localparam int word_spacing   = 10;
   localparam int margin_cycles  = 200;
   localparam int timeout_cycles = reset_cycles + hold_cycles
                                 + num_words * word_spacing + margin_cycles;

   logic                          ap;
   logic                          rst;
   logic                          in_valid;
   biq_pkg::op_e                  in_op;
   logic [biq_pkg::word_bits-1:0] in_a;
   logic [biq_pkg::word_bits-1:0] in_b;
   logic                          in_credit;
   logic                          out_valid;
   logic [biq_pkg::word_bits-1:0] out_sum;
   logic                          out_carry;
   logic                          out_zero;
   logic                          out_digit_err;
   logic                          out_carry_err;
   logic                          out_credit;
   logic                          err_reset;
   logic                          check_latch;

   integer           seed;
   biq_pkg::result_s expected_q [$];
   int               cycle;
   int               in_credits;
   int               owed_credits;
   int               granted;
   int               taken;
   int               sent;
   int               bad_words;
   logic             exp_latch;

   biq_check_adder biq_check_adder_i (
      .ap            (ap),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_op         (in_op),
      .in_a          (in_a),
      .in_b          (in_b),
      .in_credit     (in_credit),
      .out_valid     (out_valid),
      .out_sum       (out_sum),
      .out_carry     (out_carry),
      .out_zero      (out_zero),
      .out_digit_err (out_digit_err),
      .out_carry_err (out_carry_err),
      .out_credit    (out_credit),
      .err_reset     (err_reset),
      .check_latch   (check_latch)
   );

   bind biq_check_adder biq_check_adder_checker biq_check_adder_checker_i (
      .ap          (ap),
      .rst         (rst),
      .in_credit   (in_credit),
      .out_valid   (out_valid),
      .out_credit  (out_credit),
      .err_reset   (err_reset),
      .check_latch (check_latch)
   );

   initial begin
      ap = 1'b0;
      forever #(period / 2) ap = ~ap;
   end

   ////////////////////
   // Failure handling
   ////////////////////

   task automatic stop_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_failure(input string what);
      $display("%0t %s", $time, what);
      stop_run();
   endtask

   task automatic compare_word(input string name, input logic [biq_pkg::word_bits-1:0] got,
                               input logic [biq_pkg::word_bits-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic compare_latch(input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t check_latch got %b expected %b", $time, got, exp);
         stop_run();
      end
   endtask

   ////////////////////
   // Digit codes
   ////////////////////

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic int quinary_bit(input int k);
      case (k)
         0:       return biq_pkg::biq_q0;
         1:       return biq_pkg::biq_q1;
         2:       return biq_pkg::biq_q2;
         3:       return biq_pkg::biq_q3;
         default: return biq_pkg::biq_q4;
      endcase
   endfunction

   // One bi bit for the half, one quinary bit for the rest
   function automatic logic [biq_pkg::digit_bits-1:0] encode_value(input int v);
      logic [biq_pkg::digit_bits-1:0] code;
      code = '0;
      if (v >= 5) begin
         code[biq_pkg::biq_b5] = 1'b1;
      end else begin
         code[biq_pkg::biq_b0] = 1'b1;
      end
      code[quinary_bit(v % 5)] = 1'b1;
      return code;
   endfunction

   // Empty code, both bi bits, or two quinary bits
   function automatic logic [biq_pkg::digit_bits-1:0] corrupt_code(input int v, input int kind);
      logic [biq_pkg::digit_bits-1:0] code;
      code = encode_value(v);
      case (kind)
         0:       code = '0;
         1:       code[biq_pkg::biq_b0] = 1'b1;
         default: code[quinary_bit((v + 1) % 5)] = 1'b1;
      endcase
      if (kind == 1) begin
         code[biq_pkg::biq_b5] = 1'b1;
      end
      return code;
   endfunction

   ////////////////////
   // Stimulus and model
   ////////////////////

   task automatic send_word();
      int               av [biq_pkg::num_digits];
      int               bv [biq_pkg::num_digits];
      int               kind;
      int               bad_pos;
      int               digit_sum;
      int               carry_in;
      logic             all_zero;
      biq_pkg::result_s res;
      kind    = rand_below(8);
      bad_pos = (kind == 1) ? rand_below(biq_pkg::num_digits) : -1;
      // Equal operands under subtract give a zero word with a carry out
      in_op   = (kind == 0 || rand_below(2) == 0) ? biq_pkg::op_sub : biq_pkg::op_add;
      for (int i = 0; i < biq_pkg::num_digits; i++) begin
         av[i] = rand_below(10);
         bv[i] = (kind == 0) ? av[i] : rand_below(10);
         in_a[i*biq_pkg::digit_bits +: biq_pkg::digit_bits] = encode_value(av[i]);
         in_b[i*biq_pkg::digit_bits +: biq_pkg::digit_bits] = encode_value(bv[i]);
      end
      if (bad_pos >= 0) begin
         if (rand_below(2) == 0) begin
            in_a[bad_pos*biq_pkg::digit_bits +: biq_pkg::digit_bits] =
               corrupt_code(av[bad_pos], rand_below(3));
         end else begin
            in_b[bad_pos*biq_pkg::digit_bits +: biq_pkg::digit_bits] =
               corrupt_code(bv[bad_pos], rand_below(3));
         end
         bad_words++;
      end
      // Decimal add digit by digit, subtract adds the nines complement plus one
      // A bad digit leaves an empty code and passes no carry on
      carry_in = (in_op == biq_pkg::op_sub) ? 1 : 0;
      all_zero = 1'b1;
      res      = '0;
      for (int i = 0; i < biq_pkg::num_digits; i++) begin
         if (i == bad_pos) begin
            all_zero = 1'b0;
            carry_in = 0;
         end else begin
            digit_sum = av[i] + ((in_op == biq_pkg::op_sub) ? 9 - bv[i] : bv[i]) + carry_in;
            res.sum[i*biq_pkg::digit_bits +: biq_pkg::digit_bits] = encode_value(digit_sum % 10);
            if (digit_sum % 10 != 0) begin
               all_zero = 1'b0;
            end
            carry_in = digit_sum / 10;
         end
      end
      res.carry     = (carry_in != 0);
      res.zero      = all_zero;
      res.digit_err = (bad_pos >= 0);
      res.carry_err = (bad_pos >= 0);
      expected_q.push_back(res);
      in_valid = 1'b1;
   endtask

   task automatic drive_inputs();
      in_valid   = 1'b0;
      out_credit = 1'b0;
      // Back-to-back words while output credits are held back
      if (sent < num_words && in_credits > 0 && (cycle < hold_cycles || rand_below(4) != 0)) begin
         send_word();
         in_credits--;
         sent++;
      end
      // The receiver hands back a credit only for a result it has taken
      if (cycle >= hold_cycles && owed_credits > 0 && rand_below(2) == 0) begin
         out_credit = 1'b1;
         owed_credits--;
      end
      err_reset = (rand_below(24) == 0);
   endtask

   task automatic check_outputs();
      biq_pkg::result_s res;
      res = '0;
      compare_bit("in_credit", in_credit, out_valid);
      compare_latch(check_latch, exp_latch);
      if (out_valid === 1'b1) begin
         if (expected_q.size() == 0) begin
            report_failure("a result left with no word outstanding");
         end else begin
            res = expected_q.pop_front();
            taken++;
            if (taken > granted) begin
               report_failure("more results left than output credits were granted");
            end else begin
               compare_word("out_sum", out_sum, res.sum);
               compare_bit("out_carry", out_carry, res.carry);
               compare_bit("out_zero", out_zero, res.zero);
               compare_bit("out_digit_err", out_digit_err, res.digit_err);
               compare_bit("out_carry_err", out_carry_err, res.carry_err);
               owed_credits++;
            end
         end
      end
      // Latch state after the coming edge
      if (err_reset) begin
         exp_latch = 1'b0;
      end else if (out_valid === 1'b1 && (res.digit_err || res.carry_err)) begin
         exp_latch = 1'b1;
      end
      granted += out_credit;
      if (in_credit === 1'b1) begin
         in_credits++;
         if (in_credits > biq_pkg::queue_depth) begin
            report_failure("more input credits came back than were spent");
         end
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      seed         = 32'h992cd671;
      rst          = 1'b1;
      in_valid     = 1'b0;
      in_op        = biq_pkg::op_add;
      in_a         = '0;
      in_b         = '0;
      out_credit   = 1'b0;
      err_reset    = 1'b0;
      in_credits   = biq_pkg::queue_depth;
      owed_credits = 0;
      granted      = biq_pkg::out_credits_init;
      taken        = 0;
      sent         = 0;
      bad_words    = 0;
      exp_latch    = 1'b0;
      cycle        = 0;
      repeat (reset_cycles) @(posedge ap);
      #1;
      rst = 1'b0;
      @(negedge ap);
      compare_bit("out_valid", out_valid, 1'b0);
      compare_bit("in_credit", in_credit, 1'b0);
      compare_latch(check_latch, 1'b0);
      while (taken < num_words) begin
         @(posedge ap);
         #1;
         drive_inputs();
         @(negedge ap);
         check_outputs();
         cycle++;
      end
      // Quiet tail where no further result may appear
      repeat (8) begin
         @(posedge ap);
         #1;
         in_valid   = 1'b0;
         out_credit = 1'b0;
         err_reset  = 1'b0;
         @(negedge ap);
         check_outputs();
      end
      if (in_credits != biq_pkg::queue_depth) begin
         report_failure("not every input credit came back");
      end else if (bad_words == 0) begin
         report_failure("no word with an invalid digit was sent");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

   // Bounds the run by the longest expected word traffic
   initial begin
      #(timeout_cycles * period);
      report_failure("watchdog expired before all results arrived");
   end

endmodule

/* list.f */
design/biq_pkg.sv
design/digit_bus_if.sv
design/operand_feeder.sv
design/biq_digit_lane.sv
design/check_collector.sv
design/biq_check_adder.sv
tests/biq_check_adder_checker.sv
tests/biq_check_adder_tb.sv
